/* list.f */
source/sys_pkg.sv
source/bus_decode.sv
source/stack_ram.sv
source/lfsr_random.sv
source/audio_port.sv
source/bus_return.sv
source/periph_sys.sv
test/tb_periph_sys.sv

/* Makefile */
SRCS := $(wildcard source/*.sv test/*.sv)

.PHONY: run clean

run: obj_dir/Vtb_periph_sys
	./obj_dir/Vtb_periph_sys > sim.log 2>&1; cat sim.log
	grep -q "All tests passed" sim.log

obj_dir/Vtb_periph_sys: list.f $(SRCS)
	verilator --binary --timing --assert -f list.f --top-module tb_periph_sys -Mdir obj_dir

clean:
	rm -rf obj_dir sim.log

/* test/tb_periph_sys.sv */
// Testbench for the peripheral bus with a bus master model and codec loopback
`timescale 1ns/10ps
`default_nettype none

module tb_periph_sys
	import sys_pkg::*;
();

	logic cpu_clk, rst, cpu_stb_i, cpu_we_i;
	logic [1:0] cpu_sel_i;
	logic [ADDR_W-1:0] cpu_addr_i;
	logic [DATA_W-1:0] cpu_dat_i, cpu_dat_o;
	logic cpu_ack_o;
	logic [7:0] sw_i, led_o;
	logic [2:0] btn_i;
	logic ac_bclk_o, ac_lrclk_o, ac_dac_o, ac_oe_o, ac_adc_i;
	logic loop_en;

	// Expected values and check enables
	logic [DATA_W-1:0] exp_dat;
	logic rd_chk;
	int exp_lat, stb_edges;
	logic [7:0] led_m, led_exp;
	logic tx_m, rx_m, tx_chk;
	logic [DATA_W-1:0] exp_left, exp_right;
	logic [DATA_W-1:0] stack_m [2**STACK_AW];
	logic [31:0] rand_m;
	int mism, touts;

	// Serial words rebuilt from the codec pins
	logic bclk_prev, left_new, right_new;
	logic [DATA_W-1:0] lsh, rsh, left_word, right_word;
	int lcnt, rcnt, frames_done;

	periph_sys UUT (
		.cpu_clk(cpu_clk), .rst(rst), .cpu_stb_i(cpu_stb_i), .cpu_we_i(cpu_we_i),
		.cpu_sel_i(cpu_sel_i), .cpu_addr_i(cpu_addr_i), .cpu_dat_i(cpu_dat_i),
		.cpu_ack_o(cpu_ack_o), .cpu_dat_o(cpu_dat_o), .sw_i(sw_i), .btn_i(btn_i),
		.led_o(led_o), .ac_bclk_o(ac_bclk_o), .ac_lrclk_o(ac_lrclk_o),
		.ac_dac_o(ac_dac_o), .ac_oe_o(ac_oe_o), .ac_adc_i(ac_adc_i)
	);

	initial begin
		cpu_clk = 1'b0;
		forever #5 cpu_clk = ~cpu_clk;
	end

	assign ac_adc_i = loop_en ? ac_dac_o : 1'b0;

	// Button priority over the written LED value
	always_comb begin
		if (btn_i[0])
			led_exp = cpu_addr_i[23:16];
		else if (btn_i[1])
			led_exp = cpu_addr_i[15:8];
		else if (btn_i[2])
			led_exp = cpu_addr_i[7:0];
		else
			led_exp = led_m;
	end

	// Rising edges seen since the strobe went high
	always @(posedge cpu_clk) begin
		stb_edges <= cpu_stb_i ? stb_edges + 1 : 0;
	end

	always @(negedge cpu_clk) begin
		left_new <= 1'b0;
		right_new <= 1'b0;
		bclk_prev <= ac_bclk_o;
		if (rst || !ac_oe_o) begin
			lcnt <= 0;
			rcnt <= 0;
			if (rst)
				frames_done <= 0;
		end else if (ac_bclk_o && !bclk_prev) begin
			if (!ac_lrclk_o) begin
				lsh <= {lsh[DATA_W-2:0], ac_dac_o};
				lcnt <= (lcnt == AUD_BITS - 1) ? 0 : lcnt + 1;
				if (lcnt == AUD_BITS - 1) begin
					left_word <= {lsh[DATA_W-2:0], ac_dac_o};
					left_new <= 1'b1;
				end
			end else begin
				rsh <= {rsh[DATA_W-2:0], ac_dac_o};
				rcnt <= (rcnt == AUD_BITS - 1) ? 0 : rcnt + 1;
				if (rcnt == AUD_BITS - 1) begin
					right_word <= {rsh[DATA_W-2:0], ac_dac_o};
					right_new <= 1'b1;
					frames_done <= frames_done + 1;
				end
			end
		end
	end

	// ========================================================================
	// Checks
	// ========================================================================
	a_read_data: assert property (@(posedge cpu_clk) disable iff (rst)
		(cpu_ack_o && rd_chk) |-> cpu_dat_o == exp_dat)
	else begin
		mism++;
		$display("mismatch at %0t: read data %h, expected %h", $time,
			$sampled(cpu_dat_o), exp_dat);
	end

	a_ack_latency: assert property (@(posedge cpu_clk) disable iff (rst)
		cpu_ack_o |-> stb_edges == exp_lat)
	else begin
		mism++;
		$display("mismatch at %0t: acknowledge after %0d edges, expected %0d", $time,
			$sampled(stb_edges), exp_lat);
	end

	a_led_view: assert property (@(posedge cpu_clk) disable iff (rst) led_o == led_exp)
	else begin
		mism++;
		$display("mismatch at %0t: led_o %h, expected %h", $time, $sampled(led_o),
			$sampled(led_exp));
	end

	a_oe_state: assert property (@(posedge cpu_clk) disable iff (rst)
		ac_oe_o == (tx_m | rx_m))
	else begin
		mism++;
		$display("mismatch at %0t: ac_oe_o %b, expected %b", $time, $sampled(ac_oe_o),
			tx_m | rx_m);
	end

	a_tx_left: assert property (@(posedge cpu_clk) disable iff (rst)
		(tx_chk && left_new) |-> left_word == exp_left)
	else begin
		mism++;
		$display("mismatch at %0t: left word %h, expected %h", $time, left_word, exp_left);
	end

	a_tx_right: assert property (@(posedge cpu_clk) disable iff (rst)
		(tx_chk && right_new) |-> right_word == exp_right)
	else begin
		mism++;
		$display("mismatch at %0t: right word %h, expected %h", $time, right_word,
			exp_right);
	end

	a_reset_state: assert property (@(posedge cpu_clk)
		$fell(rst) |-> (!cpu_ack_o && !ac_oe_o && !ac_dac_o && led_o == 8'h00))
	else begin
		mism++;
		$display("mismatch at %0t: outputs not idle after reset", $time);
	end

	// ========================================================================
	// Models and bus master
	// ========================================================================
	function automatic logic [ADDR_W-1:0] stack_addr(input logic [STACK_AW-1:0] w);
		return {STACK_BASE_HI, 8'h00, w, 1'b0};
	endfunction

	function automatic logic [ADDR_W-1:0] reg_addr(input logic [27:0] base,
		input logic [2:0] o);
		return {base, o, 1'b0};
	endfunction

	function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old,
		input logic [DATA_W-1:0] neu, input logic [1:0] sel);
		logic [DATA_W-1:0] r;
		r = old;
		if (sel[1])
			r[15:8] = neu[15:8];
		if (sel[0])
			r[7:0] = neu[7:0];
		return r;
	endfunction

	function automatic logic [31:0] next_lfsr(input logic [31:0] s);
		return (s >> 1) ^ (s[0] ? LFSR_TAPS : 32'h0);
	endfunction

	// Seed half write, an all-zero state becomes 1
	function automatic logic [31:0] load_half(input logic [31:0] s, input logic hi,
		input logic [15:0] v);
		logic [31:0] t;
		t = s;
		if (hi)
			t[31:16] = v;
		else
			t[15:0] = v;
		return (t == 32'h0) ? 32'h1 : t;
	endfunction

	// Returns on the falling edge that sees the acknowledge, strobe already low
	task automatic access(input logic we, input logic [ADDR_W-1:0] addr,
		input logic [1:0] sel, input logic [DATA_W-1:0] wdat,
		input logic [DATA_W-1:0] edat, input int lat);
		int waited;
		@(negedge cpu_clk);
		cpu_addr_i = addr;
		cpu_we_i = we;
		cpu_sel_i = sel;
		cpu_dat_i = wdat;
		exp_dat = edat;
		rd_chk = !we;
		exp_lat = lat;
		cpu_stb_i = 1'b1;
		waited = 0;
		do begin
			@(negedge cpu_clk);
			waited++;
		end while (!cpu_ack_o && waited < 20);
		if (!cpu_ack_o) begin
			touts++;
			$display("Timeout: no acknowledge from address %h after %0d cycles", addr,
				waited);
		end
		cpu_stb_i = 1'b0;
		cpu_we_i = 1'b0;
	endtask

	task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] d,
		input int lat);
		access(1'b1, addr, 2'b11, d, '0, lat);
	endtask

	task automatic read_expect(input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] e, input int lat);
		access(1'b0, addr, 2'b11, '0, e, lat);
	endtask

	task automatic wait_frames(input int n);
		int start, waited;
		start = frames_done;
		waited = 0;
		while (frames_done < start + n && waited < 400 * n) begin
			@(negedge cpu_clk);
			waited++;
		end
		if (frames_done < start + n) begin
			touts++;
			$display("Timeout: codec frames stopped after %0d cycles", waited);
		end
	endtask

	// ========================================================================
	// Stimulus
	// ========================================================================
	initial begin
		logic [STACK_AW-1:0] woff;
		logic [DATA_W-1:0] wval, left_s, right_s;
		logic [1:0] bsel;
		logic [31:0] seed;
		logic [STACK_AW-1:0] offs [$];
		void'($urandom(32'h4873));
		rst = 1'b1;
		cpu_stb_i = 1'b0;
		cpu_we_i = 1'b0;
		cpu_sel_i = 2'b00;
		cpu_addr_i = '0;
		cpu_dat_i = '0;
		sw_i = 8'h00;
		btn_i = 3'b000;
		loop_en = 1'b0;
		exp_dat = '0;
		rd_chk = 1'b0;
		exp_lat = 0;
		led_m = 8'h00;
		tx_m = 1'b0;
		rx_m = 1'b0;
		tx_chk = 1'b0;
		exp_left = '0;
		exp_right = '0;
		mism = 0;
		touts = 0;
		repeat (8) @(posedge cpu_clk);
		@(negedge cpu_clk);
		rst = 1'b0;

		// Stack with full words, then one byte lane over each
		repeat (12) begin
			woff = STACK_AW'($urandom);
			wval = DATA_W'($urandom);
			access(1'b1, stack_addr(woff), 2'b11, wval, '0, 3);
			stack_m[woff] = wval;
			offs.push_back(woff);
			bsel = ($urandom % 2 == 0) ? 2'b01 : 2'b10;
			wval = DATA_W'($urandom);
			access(1'b1, stack_addr(woff), bsel, wval, '0, 3);
			stack_m[woff] = merge_bytes(stack_m[woff], wval, bsel);
		end
		foreach (offs[i])
			read_expect(stack_addr(offs[i]), stack_m[offs[i]], 3);

		// LED register and switches
		sw_i = 8'($urandom);
		wval = DATA_W'($urandom);
		write_reg(reg_addr(LED_BASE, 3'd0), wval, 1);
		led_m = wval[7:0];
		read_expect(reg_addr(LED_BASE, 3'd0), {8'h00, sw_i}, 1);

		// Buttons during a stack access with distinct address bytes
		woff = 11'h5A3;
		wval = DATA_W'($urandom);
		access(1'b1, stack_addr(woff), 2'b11, wval, '0, 3);
		stack_m[woff] = wval;
		for (int b = 0; b < 3; b++) begin
			btn_i = 3'(1 << b);
			read_expect(stack_addr(woff), stack_m[woff], 3);
		end
		btn_i = 3'b110;
		read_expect(stack_addr(woff), stack_m[woff], 3);
		btn_i = 3'b000;

		// ====================================================================
		// Random register
		// ====================================================================
		rand_m = 32'h1;
		seed = $urandom;
		write_reg(reg_addr(RAND_BASE, RAND_LO), seed[15:0], 1);
		rand_m = load_half(rand_m, 1'b0, seed[15:0]);
		write_reg(reg_addr(RAND_BASE, RAND_HI), seed[31:16], 1);
		rand_m = load_half(rand_m, 1'b1, seed[31:16]);
		repeat (8) begin
			read_expect(reg_addr(RAND_BASE, RAND_HI), rand_m[31:16], 1);
			rand_m = next_lfsr(rand_m);
			read_expect(reg_addr(RAND_BASE, RAND_LO), rand_m[15:0], 1);
		end
		write_reg(reg_addr(RAND_BASE, RAND_HI), 16'h0000, 1);
		rand_m = load_half(rand_m, 1'b1, 16'h0000);
		write_reg(reg_addr(RAND_BASE, RAND_LO), 16'h0000, 1);
		rand_m = load_half(rand_m, 1'b0, 16'h0000);
		read_expect(reg_addr(RAND_BASE, RAND_LO), rand_m[15:0], 1);
		read_expect(reg_addr(RAND_BASE, RAND_HI), rand_m[31:16], 1);

		// ====================================================================
		// Audio transmit, then receive through the loopback
		// ====================================================================
		left_s = DATA_W'($urandom);
		right_s = DATA_W'($urandom);
		write_reg(reg_addr(AUDIO_BASE, AUD_LEFT), left_s, 1);
		write_reg(reg_addr(AUDIO_BASE, AUD_RIGHT), right_s, 1);
		exp_left = left_s;
		exp_right = right_s;
		tx_chk = 1'b1;
		write_reg(reg_addr(AUDIO_BASE, AUD_CTRL), 16'h0002, 1);
		tx_m = 1'b1;
		wait_frames(2);
		loop_en = 1'b1;
		write_reg(reg_addr(AUDIO_BASE, AUD_CTRL), 16'h0003, 1);
		rx_m = 1'b1;
		wait_frames(2);
		read_expect(reg_addr(AUDIO_BASE, AUD_CAPT), left_s, 1);
		read_expect(reg_addr(AUDIO_BASE, AUD_CTRL), 16'h0003, 1);
		read_expect(reg_addr(AUDIO_BASE, AUD_LEFT), left_s, 1);
		read_expect(reg_addr(AUDIO_BASE, AUD_RIGHT), right_s, 1);
		tx_chk = 1'b0;
		write_reg(reg_addr(AUDIO_BASE, AUD_CTRL), 16'h0000, 1);
		tx_m = 1'b0;
		rx_m = 1'b0;
		loop_en = 1'b0;
		repeat (8) @(negedge cpu_clk);
		read_expect(reg_addr(AUDIO_BASE, AUD_CTRL), 16'h0000, 1);

		// Unmapped space answers quickly with zero
		read_expect(32'h0001_2340, 16'h0000, 1);
		write_reg(32'h0001_2340, DATA_W'($urandom), 1);
		read_expect(32'h8000_0006, 16'h0000, 1);

		repeat (4) @(negedge cpu_clk);
		$display("Run complete: %0d mismatches, %0d timeouts", mism, touts);
		if (mism == 0 && touts == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* source/periph_sys.sv */
// Peripheral bus top level joining decode, peripherals and return path
`timescale 1ns/10ps
`default_nettype none

module periph_sys
	import sys_pkg::*;
(
	input  wire logic              cpu_clk,
	input  wire logic              rst,
	input  wire logic              cpu_stb_i,
	input  wire logic              cpu_we_i,
	input  wire logic [1:0]        cpu_sel_i,
	input  wire logic [ADDR_W-1:0] cpu_addr_i,
	input  wire logic [DATA_W-1:0] cpu_dat_i,
	output logic                   cpu_ack_o,
	output logic      [DATA_W-1:0] cpu_dat_o,
	input  wire logic [7:0]        sw_i,
	input  wire logic [2:0]        btn_i,
	output logic      [7:0]        led_o,
	output logic                   ac_bclk_o,
	output logic                   ac_lrclk_o,
	output logic                   ac_dac_o,
	output logic                   ac_oe_o,
	input  wire logic              ac_adc_i
);

	logic [CS_N-1:0] cs;
	logic [2:0] off;
	logic stack_ack, rand_ack, audio_ack;
	logic [DATA_W-1:0] stack_dat, rand_dat, audio_dat;

	bus_decode u_decode (
		.cpu_clk(cpu_clk), .rst(rst), .cpu_stb_i(cpu_stb_i),
		.cpu_addr_i(cpu_addr_i), .cs_o(cs), .off_o(off)
	);

	// Word address inside the stack window
	stack_ram u_stack (
		.cpu_clk(cpu_clk), .rst(rst), .sel_i(cs[CS_STACK]),
		.cpu_stb_i(cpu_stb_i), .cpu_we_i(cpu_we_i), .cpu_sel_i(cpu_sel_i),
		.adr_i(cpu_addr_i[STACK_AW:1]), .dat_i(cpu_dat_i),
		.ack_o(stack_ack), .dat_o(stack_dat)
	);

	lfsr_random u_rand (
		.cpu_clk(cpu_clk), .rst(rst), .sel_i(cs[CS_RAND]),
		.cpu_stb_i(cpu_stb_i), .cpu_we_i(cpu_we_i), .off_i(off),
		.dat_i(cpu_dat_i), .ack_o(rand_ack), .dat_o(rand_dat)
	);

	audio_port u_audio (
		.cpu_clk(cpu_clk), .rst(rst), .sel_i(cs[CS_AUDIO]),
		.cpu_stb_i(cpu_stb_i), .cpu_we_i(cpu_we_i), .off_i(off),
		.dat_i(cpu_dat_i), .ac_adc_i(ac_adc_i),
		.ack_o(audio_ack), .dat_o(audio_dat),
		.ac_bclk_o(ac_bclk_o), .ac_lrclk_o(ac_lrclk_o),
		.ac_dac_o(ac_dac_o), .ac_oe_o(ac_oe_o)
	);

	bus_return u_return (
		.cpu_clk(cpu_clk), .rst(rst), .cs_i(cs),
		.cpu_stb_i(cpu_stb_i), .cpu_we_i(cpu_we_i),
		.cpu_dat_i(cpu_dat_i), .cpu_addr_i(cpu_addr_i),
		.stack_ack_i(stack_ack), .stack_dat_i(stack_dat),
		.rand_ack_i(rand_ack), .rand_dat_i(rand_dat),
		.audio_ack_i(audio_ack), .audio_dat_i(audio_dat),
		.sw_i(sw_i), .btn_i(btn_i),
		.cpu_ack_o(cpu_ack_o), .cpu_dat_o(cpu_dat_o), .led_o(led_o)
	);

endmodule

`default_nettype wire

/* source/bus_return.sv */
// Bus return path with LED register, short acknowledges and read data select
`timescale 1ns/10ps
`default_nettype none

module bus_return
	import sys_pkg::*;
(
	input  wire logic              cpu_clk,
	input  wire logic              rst,
	input  wire logic [CS_N-1:0]   cs_i,
	input  wire logic              cpu_stb_i,
	input  wire logic              cpu_we_i,
	input  wire logic [DATA_W-1:0] cpu_dat_i,
	input  wire logic [ADDR_W-1:0] cpu_addr_i,
	input  wire logic              stack_ack_i,
	input  wire logic [DATA_W-1:0] stack_dat_i,
	input  wire logic              rand_ack_i,
	input  wire logic [DATA_W-1:0] rand_dat_i,
	input  wire logic              audio_ack_i,
	input  wire logic [DATA_W-1:0] audio_dat_i,
	input  wire logic [7:0]        sw_i,
	input  wire logic [2:0]        btn_i,
	output logic                   cpu_ack_o,
	output logic      [DATA_W-1:0] cpu_dat_o,
	output logic      [7:0]        led_o
);

	logic led_ack, none_ack;
	logic [7:0] led_q;
	logic [CS_N-1:0] cs_q;

	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			led_ack <= 1'b0;
			none_ack <= 1'b0;
			led_q <= '0;
			cs_q <= '0;
		end else begin
			led_ack <= cs_i[CS_LED] & cpu_stb_i & ~led_ack;
			none_ack <= cs_i[CS_NONE] & cpu_stb_i & ~none_ack;
			cs_q <= cs_i;
			if (cs_i[CS_LED] && cpu_stb_i && cpu_we_i && !led_ack)
				led_q <= cpu_dat_i[7:0];
		end
	end

	assign cpu_ack_o = stack_ack_i | rand_ack_i | audio_ack_i | led_ack | none_ack;

	// Unmapped reads fall through to zero
	always_comb begin
		cpu_dat_o = '0;
		if (cs_q[CS_STACK])
			cpu_dat_o = stack_dat_i;
		else if (cs_q[CS_RAND])
			cpu_dat_o = rand_dat_i;
		else if (cs_q[CS_AUDIO])
			cpu_dat_o = audio_dat_i;
		else if (cs_q[CS_LED])
			cpu_dat_o = {{(DATA_W-8){1'b0}}, sw_i};
	end

	// Buttons override the LEDs with one byte of the bus address
	assign led_o = btn_i[0] ? cpu_addr_i[23:16] :
		btn_i[1] ? cpu_addr_i[15:8] :
		btn_i[2] ? cpu_addr_i[7:0] :
		led_q;

	a_ack_single: assert property (
		@(posedge cpu_clk) disable iff (rst)
		$onehot0({stack_ack_i, rand_ack_i, audio_ack_i, led_ack, none_ack})
	);

endmodule

`default_nettype wire

/* source/audio_port.sv */
// Audio codec port with sample registers, bit clock, frame clock and serial data
`timescale 1ns/10ps
`default_nettype none

module audio_port
	import sys_pkg::*;
(
	input  wire logic              cpu_clk,
	input  wire logic              rst,
	input  wire logic              sel_i,
	input  wire logic              cpu_stb_i,
	input  wire logic              cpu_we_i,
	input  wire logic [2:0]        off_i,
	input  wire logic [DATA_W-1:0] dat_i,
	input  wire logic              ac_adc_i,
	output logic                   ack_o,
	output logic      [DATA_W-1:0] dat_o,
	output logic                   ac_bclk_o,
	output logic                   ac_lrclk_o,
	output logic                   ac_dac_o,
	output logic                   ac_oe_o
);

	logic en_tx, en_rx;
	logic [DATA_W-1:0] left_q, right_q, capt_q;
	logic [BCLK_W-1:0] div_q;
	logic [FRAME_W-1:0] bit_q;
	logic [2*AUD_BITS-1:0] sh_out;
	logic [AUD_BITS-1:0] sh_in;
	logic fire, running, bclk_fall, bclk_rise, frame_end;

	assign fire = sel_i & cpu_stb_i & ~ack_o;
	assign running = en_tx | en_rx;
	assign bclk_fall = running && div_q == BCLK_W'(BCLK_DIV - 1);
	assign bclk_rise = running && div_q == BCLK_W'(BCLK_DIV / 2 - 1);
	assign frame_end = bclk_fall && bit_q == FRAME_W'(2 * AUD_BITS - 1);

	// ========================================================================
	// Register access
	// ========================================================================
	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			ack_o <= 1'b0;
			en_tx <= 1'b0;
			en_rx <= 1'b0;
		end else begin
			ack_o <= fire;
			if (fire && cpu_we_i && off_i == AUD_CTRL) begin
				en_tx <= dat_i[1];
				en_rx <= dat_i[0];
			end
		end
	end

	always_ff @(posedge cpu_clk) begin
		if (fire && cpu_we_i && off_i == AUD_LEFT)
			left_q <= dat_i;
		if (fire && cpu_we_i && off_i == AUD_RIGHT)
			right_q <= dat_i;
		if (fire && !cpu_we_i) begin
			case (off_i)
				AUD_CTRL:  dat_o <= {{(DATA_W-2){1'b0}}, en_tx, en_rx};
				AUD_LEFT:  dat_o <= left_q;
				AUD_RIGHT: dat_o <= right_q;
				AUD_CAPT:  dat_o <= capt_q;
				default:   dat_o <= '0;
			endcase
		end
	end

	// ========================================================================
	// Serial timing
	// ========================================================================
	// Counters rest at zero while idle so a frame starts cleanly on enable
	always_ff @(posedge cpu_clk) begin
		if (rst || !running) begin
			div_q <= '0;
			bit_q <= '0;
		end else begin
			div_q <= bclk_fall ? '0 : div_q + 1'b1;
			if (bclk_fall)
				bit_q <= bit_q + 1'b1;
		end
	end

	// Next bit goes out as the bit clock falls, left then right, MSB first
	always_ff @(posedge cpu_clk) begin
		if (!running || frame_end)
			sh_out <= {left_q, right_q};
		else if (bclk_fall)
			sh_out <= {sh_out[2*AUD_BITS-2:0], 1'b0};
	end

	// Input sampled as the bit clock rises, left word kept at end of its half
	always_ff @(posedge cpu_clk) begin
		if (en_rx && bclk_rise) begin
			sh_in <= {sh_in[AUD_BITS-2:0], ac_adc_i};
			if (bit_q == FRAME_W'(AUD_BITS - 1))
				capt_q <= {sh_in[AUD_BITS-2:0], ac_adc_i};
		end
	end

	assign ac_bclk_o = div_q >= BCLK_W'(BCLK_DIV / 2);
	assign ac_lrclk_o = bit_q[FRAME_W-1];
	assign ac_dac_o = en_tx & sh_out[2*AUD_BITS-1];
	assign ac_oe_o = running;

	// A control write that clears transmit silences the pin from the next cycle
	a_dac_quiet: assert property (
		@(posedge cpu_clk) disable iff (rst)
		(fire && cpu_we_i && off_i == AUD_CTRL && !dat_i[1]) |=> !ac_dac_o
	);

endmodule

`default_nettype wire

/* source/lfsr_random.sv */
// Random number register built on a seedable 32-bit Galois LFSR
`timescale 1ns/10ps
`default_nettype none

module lfsr_random
	import sys_pkg::*;
(
	input  wire logic              cpu_clk,
	input  wire logic              rst,
	input  wire logic              sel_i,
	input  wire logic              cpu_stb_i,
	input  wire logic              cpu_we_i,
	input  wire logic [2:0]        off_i,
	input  wire logic [DATA_W-1:0] dat_i,
	output logic                   ack_o,
	output logic      [DATA_W-1:0] dat_o
);

	logic [LFSR_W-1:0] state_q;
	logic [LFSR_W-1:0] step;
	logic [LFSR_W-1:0] wr_val;
	logic fire;

	assign fire = sel_i & cpu_stb_i & ~ack_o;

	// Shift right, fold the taps back in when a one drops out
	assign step = {1'b0, state_q[LFSR_W-1:1]} ^ (state_q[0] ? LFSR_TAPS : '0);

	always_comb begin
		wr_val = state_q;
		if (off_i == RAND_HI)
			wr_val[31:16] = dat_i;
		else
			wr_val[15:0] = dat_i;
	end

	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			ack_o <= 1'b0;
			state_q <= LFSR_W'(1);
		end else begin
			ack_o <= fire;
			if (fire && cpu_we_i && (off_i == RAND_LO || off_i == RAND_HI))
				state_q <= (wr_val == '0) ? LFSR_W'(1) : wr_val;
			else if (fire && !cpu_we_i && off_i == RAND_HI)
				state_q <= step;
		end
	end

	// Read data is taken before the high-half read advances the state
	always_ff @(posedge cpu_clk) begin
		if (fire && !cpu_we_i) begin
			case (off_i)
				RAND_LO: dat_o <= state_q[15:0];
				RAND_HI: dat_o <= state_q[31:16];
				default: dat_o <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/stack_ram.sv */
// Stack memory with byte-lane writes and a three-cycle acknowledge
`timescale 1ns/10ps
`default_nettype none

module stack_ram
	import sys_pkg::*;
(
	input  wire logic                cpu_clk,
	input  wire logic                rst,
	input  wire logic                sel_i,
	input  wire logic                cpu_stb_i,
	input  wire logic                cpu_we_i,
	input  wire logic [1:0]          cpu_sel_i,
	input  wire logic [STACK_AW-1:0] adr_i,
	input  wire logic [DATA_W-1:0]   dat_i,
	output logic                     ack_o,
	output logic      [DATA_W-1:0]   dat_o
);

	logic [DATA_W-1:0] mem [2**STACK_AW];
	logic rdy1, rdy2, rdy3;
	logic done;
	logic req;
	logic fire;

	assign req = sel_i & cpu_stb_i;
	// Third edge of an access, blocked once the access has completed
	assign fire = rdy2 & req & ~rdy3 & ~done;

	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			rdy1 <= 1'b0;
			rdy2 <= 1'b0;
			rdy3 <= 1'b0;
			done <= 1'b0;
		end else begin
			rdy1 <= req;
			rdy2 <= rdy1 & req;
			rdy3 <= fire;
			done <= (done | rdy3) & req;
		end
	end

	always_ff @(posedge cpu_clk) begin
		if (fire && cpu_we_i && cpu_sel_i[1])
			mem[adr_i][15:8] <= dat_i[15:8];
		if (fire && cpu_we_i && cpu_sel_i[0])
			mem[adr_i][7:0] <= dat_i[7:0];
		dat_o <= mem[adr_i];
	end

	assign ack_o = rdy3;

	// A held strobe would otherwise bring the acknowledge back two cycles later
	a_ack_pulse: assert property (
		@(posedge cpu_clk) disable iff (rst)
		ack_o |-> !$past(ack_o) && !$past(ack_o, 2)
	);

endmodule

`default_nettype wire

/* source/bus_decode.sv */
// Address decoder turning the bus address into one-hot chip selects
`timescale 1ns/10ps
`default_nettype none

module bus_decode
	import sys_pkg::*;
(
	input  wire logic              cpu_clk,
	input  wire logic              rst,
	input  wire logic              cpu_stb_i,
	input  wire logic [ADDR_W-1:0] cpu_addr_i,
	output logic      [CS_N-1:0]   cs_o,
	output logic      [2:0]        off_o
);

	logic hit_stack, hit_led, hit_rand, hit_audio;

	// Windows compared independently so overlapping bases would raise two selects
	assign hit_stack = cpu_addr_i[ADDR_W-1 -: 12] == STACK_BASE_HI;
	assign hit_led = cpu_addr_i[ADDR_W-1:4] == LED_BASE;
	assign hit_rand = cpu_addr_i[ADDR_W-1:4] == RAND_BASE;
	assign hit_audio = cpu_addr_i[ADDR_W-1:4] == AUDIO_BASE;

	always_comb begin
		cs_o = '0;
		cs_o[CS_STACK] = hit_stack;
		cs_o[CS_LED] = hit_led;
		cs_o[CS_RAND] = hit_rand;
		cs_o[CS_AUDIO] = hit_audio;
		cs_o[CS_NONE] = !(hit_stack | hit_led | hit_rand | hit_audio);
	end

	// Word offset inside a register block
	assign off_o = cpu_addr_i[3:1];

	a_cs_onehot: assert property (
		@(posedge cpu_clk) disable iff (rst)
		cpu_stb_i |-> $onehot(cs_o)
	);

endmodule

`default_nettype wire

/* source/sys_pkg.sv */
// Address map, bus widths and register offsets shared by the peripheral bus
`default_nettype none

package sys_pkg;

	// ========================================================================
	// Bus widths
	// ========================================================================
	localparam int ADDR_W = 32;
	localparam int DATA_W = 16;
	localparam int STACK_AW = 11;

	// ========================================================================
	// Address map
	// ========================================================================
	// Stack occupies a 1 MB window, register blocks are 16 bytes each
	localparam logic [11:0] STACK_BASE_HI = 12'hFF4;
	localparam logic [27:0] LED_BASE = 28'hFFDC060;
	localparam logic [27:0] RAND_BASE = 28'hFFDC0C0;
	localparam logic [27:0] AUDIO_BASE = 28'hFFDC070;

	typedef enum logic [2:0] {
		CS_STACK,
		CS_LED,
		CS_RAND,
		CS_AUDIO,
		CS_NONE
	} cs_index;

	localparam int CS_N = 5;

	// ========================================================================
	// Peripheral constants
	// ========================================================================
	localparam int LFSR_W = 32;
	localparam logic [LFSR_W-1:0] LFSR_TAPS = 32'h8020_0003;

	localparam int AUD_BITS = 16;
	localparam int BCLK_DIV = 4;
	localparam int BCLK_W = $clog2(BCLK_DIV);
	localparam int FRAME_W = $clog2(2 * AUD_BITS);

	// Register offsets in 16-bit words, compared against address bits 3:1
	localparam logic [2:0] AUD_CTRL = 3'd0;
	localparam logic [2:0] AUD_LEFT = 3'd2;
	localparam logic [2:0] AUD_RIGHT = 3'd4;
	localparam logic [2:0] AUD_CAPT = 3'd6;
	localparam logic [2:0] RAND_LO = 3'd0;
	localparam logic [2:0] RAND_HI = 3'd2;

endpackage

`default_nettype wire
